// File: mesh_router_pkg.sv
/*
 * Shared types for a five-port XY mesh router node. Coordinates are 2 bits,
 * so the mesh is at most 4x4. Flits are single-word packets of 24 bits.
 */

package mesh_router_pkg;

  // Router ports
  localparam int unsigned NumPorts     = 5;
  localparam int unsigned PortIdxWidth = 3;

  // Port numbering, also the bit order of every port vector
  typedef enum logic [PortIdxWidth-1:0] {
    North = 0,
    East  = 1,
    South = 2,
    West  = 3,
    Eject = 4
  } port_e;

  // Mesh coordinate of one node
  localparam int unsigned CoordWidth = 2;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_id_t;

  // Flit payload
  localparam int unsigned PayloadWidth = 16;

  // Header carried by every flit
  typedef struct packed {
    xy_id_t dst;
    xy_id_t src;
  } hdr_t;

  typedef struct packed {
    hdr_t                    hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // One bit per port, used for route requests and grants
  typedef logic [NumPorts-1:0] port_mask_t;

  // Input buffering
  // Two entries keep full throughput across the registered FIFO
  localparam int unsigned InFifoDepth = 2;

endpackage

// File: flit_fifo.sv
/*
 * Input flit buffer with valid/ready on both sides. Depth must be at least 1.
 * A full buffer still accepts a flit in the cycle its head is read.
 */

module flit_fifo #(
  parameter int unsigned Depth = mesh_router_pkg::InFifoDepth
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  mesh_router_pkg::flit_t data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output mesh_router_pkg::flit_t data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  mesh_router_pkg::flit_t mem_q [Depth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full, push, pop;

  assign full    = (count_q == CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  // Pass-through of ready lets a full buffer stream at one flit per cycle
  assign ready_o = !full || ready_i;
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Occupancy stays within bounds over any sequence of pushes and pops
  a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntWidth'(Depth))
    else $error("flit_fifo: entry count out of range");

  // Head flit holds while the reader stalls
  a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("flit_fifo: head flit changed before it was read");

endmodule

// File: xy_route_select.sv
/*
 * Dimension-ordered XY route decode for one input. X is resolved first.
 * Larger y means North. The result is always exactly one port.
 */

module xy_route_select (
  input  mesh_router_pkg::hdr_t       hdr_i,
  input  mesh_router_pkg::xy_id_t     xy_id_i,
  output mesh_router_pkg::port_mask_t route_o
);

  logic x_greater, x_less;
  logic y_greater, y_less;

  // Coordinate compares of destination against this node
  assign x_greater = (hdr_i.dst.x > xy_id_i.x);
  assign x_less    = (hdr_i.dst.x < xy_id_i.x);
  assign y_greater = (hdr_i.dst.y > xy_id_i.y);
  assign y_less    = (hdr_i.dst.y < xy_id_i.y);

  always_comb begin
    route_o = '0;
    if (x_greater) begin
      route_o[mesh_router_pkg::East] = 1'b1;
    end else if (x_less) begin
      route_o[mesh_router_pkg::West] = 1'b1;
    end else if (y_greater) begin
      // Same column, travel along y
      route_o[mesh_router_pkg::North] = 1'b1;
    end else if (y_less) begin
      route_o[mesh_router_pkg::South] = 1'b1;
    end else begin
      // Arrived at this node
      route_o[mesh_router_pkg::Eject] = 1'b1;
    end
  end

endmodule

// File: output_arbiter.sv
/*
 * Round-robin arbiter and flit mux for one output port. Combinational from
 * request to grant. The grant is held while the output is stalled, and the
 * priority pointer moves past the winner only on a completed transfer.
 */

module output_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  mesh_router_pkg::port_mask_t                       req_i,
  input  mesh_router_pkg::flit_t [mesh_router_pkg::NumPorts-1:0] data_i,
  input  logic                                              ready_i,
  output mesh_router_pkg::port_mask_t                       gnt_o,
  output logic                                              valid_o,
  output mesh_router_pkg::flit_t                            data_o
);

  logic [mesh_router_pkg::PortIdxWidth-1:0] ptr_q;
  logic [mesh_router_pkg::PortIdxWidth-1:0] win_idx, sel_idx, sel_q;
  mesh_router_pkg::port_mask_t              rr_gnt;
  logic                                     lock_q;

  // First requester at or after the pointer wins
  always_comb begin : rr_pick
    int unsigned idx;
    logic        found;
    rr_gnt  = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int unsigned i = 0; i < mesh_router_pkg::NumPorts; i++) begin
      idx = (32'(ptr_q) + i) % mesh_router_pkg::NumPorts;
      if (!found && req_i[idx]) begin
        found       = 1'b1;
        rr_gnt[idx] = 1'b1;
        win_idx     = idx[mesh_router_pkg::PortIdxWidth-1:0];
      end
    end
  end

  // A stalled output keeps its previous winner
  assign sel_idx = lock_q ? sel_q : win_idx;
  assign gnt_o   = lock_q ? (mesh_router_pkg::port_mask_t'(1) << sel_q) : rr_gnt;
  assign valid_o = |gnt_o;
  assign data_o  = data_i[sel_idx];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= valid_o && !ready_i;
      if (valid_o && ready_i) begin
        // Winner drops to lowest priority
        if (sel_idx == mesh_router_pkg::PortIdxWidth'(mesh_router_pkg::NumPorts - 1)) begin
          ptr_q <= '0;
        end else begin
          ptr_q <= sel_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_o && !ready_i) begin
      sel_q <= sel_idx;
    end
  end

  a_gnt_onehot0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o))
    else $error("output_arbiter: grant %b has more than one bit set", gnt_o);

  // Stalled output keeps both valid and the flit
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("output_arbiter: output changed under back-pressure");

endmodule

// File: mesh_router.sv
/*
 * Five-port mesh router node with one channel per port and XY routing.
 * Input FIFOs feed a crossbar that blocks loopback and turns from North or
 * South into East or West. Senders must only inject legal destinations.
 */

module mesh_router (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  mesh_router_pkg::xy_id_t                                xy_id_i,
  input  mesh_router_pkg::port_mask_t                            valid_i,
  output mesh_router_pkg::port_mask_t                            ready_o,
  input  mesh_router_pkg::flit_t [mesh_router_pkg::NumPorts-1:0] data_i,
  output mesh_router_pkg::port_mask_t                            valid_o,
  input  mesh_router_pkg::port_mask_t                            ready_i,
  output mesh_router_pkg::flit_t [mesh_router_pkg::NumPorts-1:0] data_o
);

  localparam int NumPorts = mesh_router_pkg::NumPorts;

  // Input side, indexed by input port
  mesh_router_pkg::flit_t [NumPorts-1:0]      in_data;
  mesh_router_pkg::port_mask_t                in_valid, in_ready;
  mesh_router_pkg::port_mask_t [NumPorts-1:0] route_mask;
  // Per input, one bit per output that accepted its flit
  mesh_router_pkg::port_mask_t [NumPorts-1:0] in_ack;

  // Output side, indexed by output port, one bit per input
  mesh_router_pkg::port_mask_t [NumPorts-1:0] out_req, out_gnt;

  for (genvar in = 0; in < NumPorts; in++) begin : gen_input
    flit_fifo #(
      .Depth ( mesh_router_pkg::InFifoDepth )
    ) i_flit_fifo (
      .clk_i   ( clk_i        ),
      .rst_n_i ( rst_n_i      ),
      .valid_i ( valid_i[in]  ),
      .ready_o ( ready_o[in]  ),
      .data_i  ( data_i[in]   ),
      .valid_o ( in_valid[in] ),
      .ready_i ( in_ready[in] ),
      .data_o  ( in_data[in]  )
    );

    xy_route_select i_route_select (
      .hdr_i   ( in_data[in].hdr ),
      .xy_id_i ( xy_id_i         ),
      .route_o ( route_mask[in]  )
    );
  end

  // Crossbar with the fixed connection mask
  for (genvar in = 0; in < NumPorts; in++) begin : gen_xbar_in
    for (genvar out = 0; out < NumPorts; out++) begin : gen_xbar_out
      if ((in == out) ||
          ((in == int'(mesh_router_pkg::North) || in == int'(mesh_router_pkg::South)) &&
           (out == int'(mesh_router_pkg::East) || out == int'(mesh_router_pkg::West))))
      begin : gen_no_conn
        assign out_req[out][in] = 1'b0;
        assign in_ack[in][out]  = 1'b0;
      end else begin : gen_conn
        assign out_req[out][in] = in_valid[in] & route_mask[in][out];
        assign in_ack[in][out]  = out_gnt[out][in] & ready_i[out];
      end
    end
    // Single destination, so one accepting output pops the flit
    assign in_ready[in] = |in_ack[in];
  end

  for (genvar out = 0; out < NumPorts; out++) begin : gen_output
    output_arbiter i_output_arbiter (
      .clk_i   ( clk_i        ),
      .rst_n_i ( rst_n_i      ),
      .req_i   ( out_req[out] ),
      .data_i  ( in_data      ),
      .ready_i ( ready_i[out] ),
      .gnt_o   ( out_gnt[out] ),
      .valid_o ( valid_o[out] ),
      .data_o  ( data_o[out]  )
    );
  end

  // Y to X turns would be silently dropped by the mask
  a_no_yx_turn: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(in_valid[mesh_router_pkg::North] &&
      (route_mask[mesh_router_pkg::North][mesh_router_pkg::East] ||
       route_mask[mesh_router_pkg::North][mesh_router_pkg::West])) &&
    !(in_valid[mesh_router_pkg::South] &&
      (route_mask[mesh_router_pkg::South][mesh_router_pkg::East] ||
       route_mask[mesh_router_pkg::South][mesh_router_pkg::West])))
    else $error("mesh_router: head flit turns from North or South into East or West");

  for (genvar in = 0; in < NumPorts; in++) begin : gen_in_assert
    a_no_loopback: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(in_valid[in] && route_mask[in][in]))
      else $error("mesh_router: head flit on input %0d routes back to itself", in);

    a_valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_i[in] && !ready_o[in] |=> valid_i[in])
      else $error("mesh_router: valid dropped on input %0d before transfer", in);
  end

endmodule

// File: tb_mesh_router_pkg.sv
/*
 * Testbench helpers for the mesh router. The LFSR is a 16-bit Fibonacci
 * register for x^16 + x^14 + x^13 + x^11 + 1, so its seed must be nonzero.
 */

package tb_mesh_router_pkg;

  // Port numbers as plain integers for loops and queue indices
  localparam int unsigned PortNorth = mesh_router_pkg::North;
  localparam int unsigned PortEast  = mesh_router_pkg::East;
  localparam int unsigned PortSouth = mesh_router_pkg::South;
  localparam int unsigned PortWest  = mesh_router_pkg::West;
  localparam int unsigned PortEject = mesh_router_pkg::Eject;

  // One LFSR step, the new bit enters at bit 0
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  // Expected output port, the x offset is removed before the y offset
  function automatic int unsigned ref_route(input mesh_router_pkg::xy_id_t dst,
                                            input mesh_router_pkg::xy_id_t node);
    if (dst.x != node.x) begin
      return (dst.x > node.x) ? PortEast : PortWest;
    end
    if (dst.y != node.y) begin
      return (dst.y > node.y) ? PortNorth : PortSouth;
    end
    return PortEject;
  endfunction

  // No loopback and no turn from the y axis onto the x axis
  function automatic bit is_legal(input int unsigned in_port,
                                  input mesh_router_pkg::xy_id_t dst,
                                  input mesh_router_pkg::xy_id_t node);
    int unsigned out_port;
    out_port = ref_route(dst, node);
    if (out_port == in_port) begin
      return 1'b0;
    end
    if ((in_port == PortNorth || in_port == PortSouth) &&
        (out_port == PortEast || out_port == PortWest)) begin
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // Coordinate of the neighbour behind an input, the node itself for Eject
  function automatic mesh_router_pkg::xy_id_t src_of_port(input int unsigned port,
                                                          input mesh_router_pkg::xy_id_t node);
    mesh_router_pkg::xy_id_t src;
    src = node;
    case (port)
      PortNorth: src.y = node.y + 2'd1;
      PortEast:  src.x = node.x + 2'd1;
      PortSouth: src.y = node.y - 2'd1;
      PortWest:  src.x = node.x - 2'd1;
      default:   src = node;
    endcase
    return src;
  endfunction

  // Returns NumPorts when the coordinate matches no input
  function automatic int unsigned port_of_src(input mesh_router_pkg::xy_id_t src,
                                              input mesh_router_pkg::xy_id_t node);
    for (int unsigned p = 0; p < mesh_router_pkg::NumPorts; p++) begin
      if (src_of_port(p, node) == src) begin
        return p;
      end
    end
    return mesh_router_pkg::NumPorts;
  endfunction

  function automatic mesh_router_pkg::flit_t make_flit(input mesh_router_pkg::xy_id_t dst,
                                                       input mesh_router_pkg::xy_id_t src,
                                                       input logic [15:0] payload);
    mesh_router_pkg::flit_t flit;
    flit.hdr.dst = dst;
    flit.hdr.src = src;
    flit.payload = payload;
    return flit;
  endfunction

endpackage

// File: tb_mesh_router.sv
/*
 * Testbench for one router node placed at (1,1). A flit's src field holds
 * the neighbour coordinate of its input, which is how the compare process
 * finds the queue of expected flits. Only legal destinations are sent.
 */

module tb_mesh_router;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumPorts = mesh_router_pkg::NumPorts;
  localparam int unsigned Timeout  = 4000;
  localparam int unsigned Burst    = 20;
  localparam mesh_router_pkg::xy_id_t NodeId = '{x: 2'd1, y: 2'd1};

  logic                                  clk_i = 1'b0;
  logic                                  rst_n_i;
  mesh_router_pkg::port_mask_t           in_valid = '0;
  mesh_router_pkg::port_mask_t           in_ready, out_valid, out_ready;
  mesh_router_pkg::flit_t [NumPorts-1:0] in_data = '0;
  mesh_router_pkg::flit_t [NumPorts-1:0] out_data;

  // Pending stimulus per input, expected flits per (input, output) pair
  mesh_router_pkg::flit_t tx_q [NumPorts][$];
  mesh_router_pkg::flit_t exp_q [NumPorts][NumPorts][$];
  int unsigned            fair_src_q [$];
  logic                   fair_mode = 1'b0;

  // Output state of the previous edge, for the stall check
  logic                   stalled_q [NumPorts];
  mesh_router_pkg::flit_t held_q [NumPorts];

  logic [15:0] lfsr_q;
  int unsigned value_errors = 0;
  int unsigned stray_flits  = 0;
  int unsigned check_errors = 0;
  int unsigned timeouts     = 0;

  always #20 clk_i = ~clk_i;

  mesh_router i_mesh_router (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .xy_id_i ( NodeId    ),
    .valid_i ( in_valid  ),
    .ready_o ( in_ready  ),
    .data_i  ( in_data   ),
    .valid_o ( out_valid ),
    .ready_i ( out_ready ),
    .data_o  ( out_data  )
  );

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = tb_mesh_router_pkg::lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
    return value;
  endfunction

  function automatic mesh_router_pkg::flit_t random_flit(input int unsigned in_port);
    mesh_router_pkg::xy_id_t dst;
    do begin
      dst = 4'(rand_bits(4));
    end while (!tb_mesh_router_pkg::is_legal(in_port, dst, NodeId));
    return tb_mesh_router_pkg::make_flit(dst, tb_mesh_router_pkg::src_of_port(in_port, NodeId),
                                         16'(rand_bits(16)));
  endfunction

  function automatic bit all_idle();
    if (in_valid != '0) begin
      return 1'b0;
    end
    for (int unsigned i = 0; i < NumPorts; i++) begin
      if (tx_q[i].size() != 0) begin
        return 1'b0;
      end
      for (int unsigned o = 0; o < NumPorts; o++) begin
        if (exp_q[i][o].size() != 0) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  // Runs until every sent flit has come out, optionally with random ready_i
  task automatic drain_traffic(input string what, input bit toggle_ready);
    int unsigned cycles;
    cycles = 0;
    while (!all_idle() && cycles < Timeout) begin
      @(posedge clk_i);
      if (toggle_ready) begin
        out_ready <= mesh_router_pkg::port_mask_t'(rand_bits(NumPorts));
      end
      cycles++;
    end
    out_ready <= '1;
    if (!all_idle()) begin
      timeouts++;
      $display("Timeout at %0t: %s traffic still pending after %0d cycles", $time, what,
               Timeout);
    end
  endtask

  // Input drivers, each holds its flit until the router takes it
  always @(posedge clk_i) begin
    mesh_router_pkg::flit_t next_flit;
    int unsigned            out_port;
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (in_valid[p] && in_ready[p]) begin
        out_port = tb_mesh_router_pkg::ref_route(in_data[p].hdr.dst, NodeId);
        exp_q[p][out_port].push_back(in_data[p]);
      end
      if (!in_valid[p] || in_ready[p]) begin
        if (tx_q[p].size() > 0) begin
          next_flit = tx_q[p].pop_front();
          in_data[p]  <= next_flit;
          in_valid[p] <= 1'b1;
        end else begin
          in_valid[p] <= 1'b0;
        end
      end
    end
  end

  // Compare process for output transfers and stalled outputs
  always @(posedge clk_i) begin
    int unsigned            src;
    mesh_router_pkg::flit_t exp_flit;
    for (int unsigned o = 0; o < NumPorts; o++) begin
      if (!rst_n_i) begin
        stalled_q[o] = 1'b0;
      end else begin
        if (stalled_q[o]) begin
          if (out_valid[o] !== 1'b1) begin
            value_errors++;
            $display("FAILED at %0t: valid_o[%0d] expected 1, got %b", $time, o, out_valid[o]);
          end
          if (out_data[o] !== held_q[o]) begin
            value_errors++;
            $display("FAILED at %0t: data_o[%0d] expected %h, got %h", $time, o, held_q[o],
                     out_data[o]);
          end
        end
        stalled_q[o] = out_valid[o] && !out_ready[o];
        held_q[o]    = out_data[o];
        if (out_valid[o] && out_ready[o]) begin
          src = tb_mesh_router_pkg::port_of_src(out_data[o].hdr.src, NodeId);
          if (src >= NumPorts || exp_q[src][o].size() == 0) begin
            stray_flits++;
            $display("Error at %0t: output %0d sent flit %h that no input was waiting for",
                     $time, o, out_data[o]);
          end else begin
            exp_flit = exp_q[src][o].pop_front();
            if (out_data[o] !== exp_flit) begin
              value_errors++;
              $display("FAILED at %0t: data_o[%0d] expected %h, got %h", $time, o, exp_flit,
                       out_data[o]);
            end
            if (fair_mode && o == tb_mesh_router_pkg::PortEject) begin
              fair_src_q.push_back(src);
            end
          end
        end
      end
    end
  end

  initial begin : main_sequence
    mesh_router_pkg::xy_id_t dst;
    int unsigned             expected_src;
    lfsr_q = 16'd43;
    rst_n_i   <= 1'b0;
    out_ready <= '1;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Idle outputs and open inputs once reset is released
    repeat (2) begin
      @(posedge clk_i);
      if (out_valid !== '0) begin
        check_errors++;
        $display("FAILED at %0t: valid_o expected %b, got %b", $time, 5'b00000, out_valid);
      end
      if (in_ready !== '1) begin
        check_errors++;
        $display("FAILED at %0t: ready_o expected %b, got %b", $time, 5'b11111, in_ready);
      end
    end

    // Every legal destination from every input
    for (int unsigned p = 0; p < NumPorts; p++) begin
      for (int unsigned d = 0; d < 16; d++) begin
        dst = d[3:0];
        if (tb_mesh_router_pkg::is_legal(p, dst, NodeId)) begin
          tx_q[p].push_back(tb_mesh_router_pkg::make_flit(dst,
            tb_mesh_router_pkg::src_of_port(p, NodeId), 16'(rand_bits(16))));
        end
      end
    end
    drain_traffic("routing", 1'b0);

    // Random burst on all inputs at once
    for (int unsigned k = 0; k < Burst; k++) begin
      for (int unsigned p = 0; p < NumPorts; p++) begin
        tx_q[p].push_back(random_flit(p));
      end
    end
    drain_traffic("burst", 1'b0);

    // East and West compete for Eject
    fair_mode = 1'b1;
    for (int unsigned k = 0; k < Burst; k++) begin
      tx_q[tb_mesh_router_pkg::PortEast].push_back(tb_mesh_router_pkg::make_flit(NodeId,
        tb_mesh_router_pkg::src_of_port(tb_mesh_router_pkg::PortEast, NodeId),
        16'(rand_bits(16))));
      tx_q[tb_mesh_router_pkg::PortWest].push_back(tb_mesh_router_pkg::make_flit(NodeId,
        tb_mesh_router_pkg::src_of_port(tb_mesh_router_pkg::PortWest, NodeId),
        16'(rand_bits(16))));
    end
    drain_traffic("fairness", 1'b0);
    fair_mode = 1'b0;
    if (fair_src_q.size() != 2 * Burst) begin
      check_errors++;
      $display("Error at %0t: %0d flits reached Eject in the fairness run, %0d were sent",
               $time, fair_src_q.size(), 2 * Burst);
    end
    for (int unsigned i = 1; i < fair_src_q.size(); i++) begin
      expected_src = (fair_src_q[i-1] == tb_mesh_router_pkg::PortEast) ?
                     tb_mesh_router_pkg::PortWest : tb_mesh_router_pkg::PortEast;
      if (fair_src_q[i] != expected_src) begin
        check_errors++;
        $display("FAILED at %0t: data_o[4] source of grant %0d expected %0d, got %0d",
                 $time, i, expected_src, fair_src_q[i]);
      end
    end

    // Random burst with random back-pressure on every output
    for (int unsigned k = 0; k < Burst; k++) begin
      for (int unsigned p = 0; p < NumPorts; p++) begin
        tx_q[p].push_back(random_flit(p));
      end
    end
    drain_traffic("back-pressure", 1'b1);

    @(posedge clk_i);
    $display("Errors: %0d output value, %0d stray flit, %0d sequence check, %0d timeout",
             value_errors, stray_flits, check_errors, timeouts);
    if (value_errors + stray_flits + check_errors + timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: mesh_router.f
mesh_router_pkg.sv
flit_fifo.sv
xy_route_select.sv
output_arbiter.sv
mesh_router.sv
tb_mesh_router_pkg.sv
tb_mesh_router.sv

// File: run_sim.sh
#!/bin/sh
# Builds the mesh router testbench with Verilator and runs it.
# Exits non-zero if the build fails, the run aborts or the log reports a failure.

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_mesh_router -f mesh_router.f -o tb_mesh_router \
  && { ./obj_dir/tb_mesh_router > "$LOG" 2>&1; STATUS=$?; cat "$LOG"; [ "$STATUS" -eq 0 ]; } \
  && ! grep -q "tests failed" "$LOG" \
  && echo "Simulation finished without failures" \
  || { echo "Simulation failed, see $LOG"; exit 1; }

exit 0
